//--- cu_params.svh
`ifndef CU_PARAMS_SVH
`define CU_PARAMS_SVH

// Instruction fields
`define CU_OP_W        6
`define CU_FUNCT_W     6

// Datapath selects
`define CU_ALUOP_W     3
`define CU_SRCB_W      2
`define CU_PCSRC_W     3
`define CU_IORD_W      3
`define CU_MEMTOREG_W  4
`define CU_REGDST_W    3
`define CU_BRANCHOP_W  2
`define CU_LSIZE_W     2

`endif

//--- mips_isa_pkg.sv
`include "cu_params.svh"

package mips_isa_pkg;

    typedef logic [`CU_OP_W-1:0]    opcode_t;
    typedef logic [`CU_FUNCT_W-1:0] funct_t;

    // R-type, decoded further by the function field
    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_j     = 6'h02;
    localparam opcode_t op_jal   = 6'h03;
    localparam opcode_t op_beq   = 6'h04;
    localparam opcode_t op_bne   = 6'h05;
    localparam opcode_t op_ble   = 6'h06;
    localparam opcode_t op_bgt   = 6'h07;
    localparam opcode_t op_addi  = 6'h08;
    localparam opcode_t op_addiu = 6'h09;
    localparam opcode_t op_slti  = 6'h0a;
    localparam opcode_t op_lui   = 6'h0f;

    localparam funct_t fn_jr   = 6'h08;
    localparam funct_t fn_mfhi = 6'h10;
    localparam funct_t fn_mflo = 6'h12;
    localparam funct_t fn_mult = 6'h18;
    localparam funct_t fn_div  = 6'h1a;
    localparam funct_t fn_add  = 6'h20;
    localparam funct_t fn_sub  = 6'h22;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_slt  = 6'h2a;

    typedef enum logic [4:0] {
        cls_add, cls_sub, cls_and, cls_slt,
        cls_addi, cls_addiu, cls_slti, cls_lui,
        cls_beq, cls_bne, cls_ble, cls_bgt,
        cls_j, cls_jal, cls_jr,
        cls_mult, cls_div, cls_mfhi, cls_mflo,
        cls_invalid
    } instr_class_t;

endpackage

//--- cu_ctrl_pkg.sv
`include "cu_params.svh"

package cu_ctrl_pkg;

    typedef enum logic [4:0] {
        st_fetch1, st_fetch2,
        st_decode1, st_decode2, st_decode3, st_decode4,
        st_exec, st_writeback, st_branch, st_jump,
        st_muldiv_start, st_muldiv_wait, st_hilo_write,
        st_trap_epc, st_trap_addr, st_trap_wait, st_trap_load, st_trap_jump
    } cu_state_t;

    typedef enum logic [1:0] {
        trap_invalid,
        trap_overflow,
        trap_div_zero
    } trap_cause_t;

    typedef logic [`CU_ALUOP_W-1:0]    alu_op_t;
    typedef logic [`CU_SRCB_W-1:0]     alu_src_b_t;
    typedef logic [`CU_PCSRC_W-1:0]    pc_src_t;
    typedef logic [`CU_IORD_W-1:0]     iord_t;
    typedef logic [`CU_MEMTOREG_W-1:0] mem_to_reg_t;
    typedef logic [`CU_REGDST_W-1:0]   reg_dst_t;
    typedef logic [`CU_BRANCHOP_W-1:0] branch_op_t;
    typedef logic [`CU_LSIZE_W-1:0]    load_size_t;

    localparam alu_op_t alu_pass_a = 3'd0;
    localparam alu_op_t alu_add    = 3'd1;
    localparam alu_op_t alu_sub    = 3'd2;
    localparam alu_op_t alu_and    = 3'd3;
    localparam alu_op_t alu_cmp    = 3'd7;

    localparam alu_src_b_t srcb_b      = 2'd0;
    localparam alu_src_b_t srcb_four   = 2'd1;
    localparam alu_src_b_t srcb_imm    = 2'd2;
    localparam alu_src_b_t srcb_offset = 2'd3; // Shifted immediate

    localparam pc_src_t pcsrc_alu    = 3'd0;
    localparam pc_src_t pcsrc_aluout = 3'd1;
    localparam pc_src_t pcsrc_jump   = 3'd2;
    localparam pc_src_t pcsrc_vector = 3'd6; // Byte loaded into MDR

    // Trap vector addresses in memory
    localparam iord_t iord_pc      = 3'd0;
    localparam iord_t iord_inv_vec = 3'd2;
    localparam iord_t iord_ovf_vec = 3'd3;
    localparam iord_t iord_dz_vec  = 3'd4;

    localparam mem_to_reg_t m2r_aluout = 4'd0;
    localparam mem_to_reg_t m2r_hi     = 4'd2;
    localparam mem_to_reg_t m2r_lo     = 4'd3;
    localparam mem_to_reg_t m2r_lui    = 4'd6;
    localparam mem_to_reg_t m2r_cmp    = 4'd8;

    localparam reg_dst_t rdst_rt = 3'd0;
    localparam reg_dst_t rdst_ra = 3'd2;
    localparam reg_dst_t rdst_rd = 3'd3;

    localparam branch_op_t br_eq = 2'd0;
    localparam branch_op_t br_ne = 2'd1;
    localparam branch_op_t br_gt = 2'd2;
    localparam branch_op_t br_le = 2'd3;

    localparam load_size_t lsize_word = 2'd0;
    localparam load_size_t lsize_byte = 2'd3;

endpackage

//--- instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  mips_isa_pkg::opcode_t      op,
    input  mips_isa_pkg::funct_t       funct,
    output mips_isa_pkg::instr_class_t instr_class
);

    always_comb begin
        instr_class = mips_isa_pkg::cls_invalid;
        if (op == mips_isa_pkg::op_rtype) begin
            case (funct)
                mips_isa_pkg::fn_add:  instr_class = mips_isa_pkg::cls_add;
                mips_isa_pkg::fn_sub:  instr_class = mips_isa_pkg::cls_sub;
                mips_isa_pkg::fn_and:  instr_class = mips_isa_pkg::cls_and;
                mips_isa_pkg::fn_slt:  instr_class = mips_isa_pkg::cls_slt;
                mips_isa_pkg::fn_jr:   instr_class = mips_isa_pkg::cls_jr;
                mips_isa_pkg::fn_mult: instr_class = mips_isa_pkg::cls_mult;
                mips_isa_pkg::fn_div:  instr_class = mips_isa_pkg::cls_div;
                mips_isa_pkg::fn_mfhi: instr_class = mips_isa_pkg::cls_mfhi;
                mips_isa_pkg::fn_mflo: instr_class = mips_isa_pkg::cls_mflo;
                default:               instr_class = mips_isa_pkg::cls_invalid; // Shifts etc.
            endcase
        end else begin
            case (op)
                mips_isa_pkg::op_addi:  instr_class = mips_isa_pkg::cls_addi;
                mips_isa_pkg::op_addiu: instr_class = mips_isa_pkg::cls_addiu;
                mips_isa_pkg::op_slti:  instr_class = mips_isa_pkg::cls_slti;
                mips_isa_pkg::op_lui:   instr_class = mips_isa_pkg::cls_lui;
                mips_isa_pkg::op_beq:   instr_class = mips_isa_pkg::cls_beq;
                mips_isa_pkg::op_bne:   instr_class = mips_isa_pkg::cls_bne;
                mips_isa_pkg::op_ble:   instr_class = mips_isa_pkg::cls_ble;
                mips_isa_pkg::op_bgt:   instr_class = mips_isa_pkg::cls_bgt;
                mips_isa_pkg::op_j:     instr_class = mips_isa_pkg::cls_j;
                mips_isa_pkg::op_jal:   instr_class = mips_isa_pkg::cls_jal;
                // Loads, stores and SRAM land here
                default:                instr_class = mips_isa_pkg::cls_invalid;
            endcase
        end
    end

endmodule

//--- cycle_sequencer.sv
`timescale 1ns/1ns

module cycle_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  mips_isa_pkg::instr_class_t instr_class,
    input  logic                       overflow,
    input  logic                       mult_done,
    input  logic                       div_done,
    input  logic                       div_zero,
    output cu_ctrl_pkg::cu_state_t     state,
    output cu_ctrl_pkg::trap_cause_t   trap_cause
);

    cu_ctrl_pkg::cu_state_t   state_next;
    cu_ctrl_pkg::trap_cause_t cause_next;
    logic                     is_div;    // Running unit is the divider
    logic                     link;      // JAL still owes its jump
    logic                     ovf_class;
    logic                     op_done;

    // Only signed adds and subtracts trap on overflow
    assign ovf_class = instr_class inside {mips_isa_pkg::cls_add, mips_isa_pkg::cls_sub,
                                           mips_isa_pkg::cls_addi};
    assign op_done   = is_div ? div_done : mult_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= cu_ctrl_pkg::st_fetch1;
            trap_cause <= cu_ctrl_pkg::trap_invalid;
            is_div     <= 1'b0;
            link       <= 1'b0;
        end else begin
            state      <= state_next;
            trap_cause <= cause_next;
            if (state == cu_ctrl_pkg::st_decode4) begin
                is_div <= (instr_class == mips_isa_pkg::cls_div);
                link   <= (instr_class == mips_isa_pkg::cls_jal);
            end
        end
    end

    always_comb begin
        state_next = state;
        cause_next = trap_cause;
        case (state)
            cu_ctrl_pkg::st_fetch1:  state_next = cu_ctrl_pkg::st_fetch2;
            cu_ctrl_pkg::st_fetch2:  state_next = cu_ctrl_pkg::st_decode1;
            cu_ctrl_pkg::st_decode1: state_next = cu_ctrl_pkg::st_decode2;
            cu_ctrl_pkg::st_decode2: state_next = cu_ctrl_pkg::st_decode3;
            cu_ctrl_pkg::st_decode3: state_next = cu_ctrl_pkg::st_decode4;
            cu_ctrl_pkg::st_decode4: begin
                case (instr_class)
                    mips_isa_pkg::cls_lui, mips_isa_pkg::cls_mfhi, mips_isa_pkg::cls_mflo:
                        state_next = cu_ctrl_pkg::st_writeback;
                    mips_isa_pkg::cls_beq, mips_isa_pkg::cls_bne,
                    mips_isa_pkg::cls_ble, mips_isa_pkg::cls_bgt:
                        state_next = cu_ctrl_pkg::st_branch;
                    mips_isa_pkg::cls_j:
                        state_next = cu_ctrl_pkg::st_jump;
                    mips_isa_pkg::cls_mult, mips_isa_pkg::cls_div:
                        state_next = cu_ctrl_pkg::st_muldiv_start;
                    mips_isa_pkg::cls_invalid: begin
                        state_next = cu_ctrl_pkg::st_trap_epc;
                        cause_next = cu_ctrl_pkg::trap_invalid;
                    end
                    default:
                        state_next = cu_ctrl_pkg::st_exec;
                endcase
            end
            cu_ctrl_pkg::st_exec: begin
                if (overflow && ovf_class) begin
                    state_next = cu_ctrl_pkg::st_trap_epc;
                    cause_next = cu_ctrl_pkg::trap_overflow;
                end else if (instr_class == mips_isa_pkg::cls_jr) begin
                    state_next = cu_ctrl_pkg::st_jump;
                end else begin
                    state_next = cu_ctrl_pkg::st_writeback;
                end
            end
            cu_ctrl_pkg::st_writeback:
                state_next = link ? cu_ctrl_pkg::st_jump : cu_ctrl_pkg::st_fetch1;
            cu_ctrl_pkg::st_muldiv_start: state_next = cu_ctrl_pkg::st_muldiv_wait;
            cu_ctrl_pkg::st_muldiv_wait: begin
                if (is_div && div_zero) begin
                    state_next = cu_ctrl_pkg::st_trap_epc;
                    cause_next = cu_ctrl_pkg::trap_div_zero;
                end else if (op_done) begin
                    state_next = cu_ctrl_pkg::st_hilo_write;
                end
            end
            cu_ctrl_pkg::st_trap_epc:  state_next = cu_ctrl_pkg::st_trap_addr;
            cu_ctrl_pkg::st_trap_addr: state_next = cu_ctrl_pkg::st_trap_wait;
            cu_ctrl_pkg::st_trap_wait: state_next = cu_ctrl_pkg::st_trap_load;
            cu_ctrl_pkg::st_trap_load: state_next = cu_ctrl_pkg::st_trap_jump;
            // Branch, jump, hilo write and trap jump all finish here
            default: state_next = cu_ctrl_pkg::st_fetch1;
        endcase
    end

endmodule

//--- control_encoder.sv
`timescale 1ns/1ns

module control_encoder (
    input  cu_ctrl_pkg::cu_state_t     state,
    input  mips_isa_pkg::instr_class_t instr_class,
    input  cu_ctrl_pkg::trap_cause_t   trap_cause,
    output cu_ctrl_pkg::alu_op_t       alu_op,
    output logic                       alu_src_a,  // 0 PC, 1 A
    output cu_ctrl_pkg::alu_src_b_t    alu_src_b,
    output cu_ctrl_pkg::pc_src_t       pc_src,
    output cu_ctrl_pkg::iord_t         iord,
    output cu_ctrl_pkg::mem_to_reg_t   mem_to_reg,
    output cu_ctrl_pkg::reg_dst_t      reg_dst,
    output cu_ctrl_pkg::branch_op_t    branch_op,
    output cu_ctrl_pkg::load_size_t    load_size,
    output logic                       pc_write,
    output logic                       pc_write_cond,
    output logic                       reg_write,
    output logic                       mem_write,
    output logic                       ir_load,
    output logic                       ab_load,
    output logic                       aluout_load,
    output logic                       epc_load,
    output logic                       hilo_load,
    output logic                       hilo_src,   // 1 takes the multiplier
    output logic                       mdr_load,
    output logic                       mult_start,
    output logic                       div_start
);

    logic use_imm;

    assign use_imm = instr_class inside {mips_isa_pkg::cls_addi, mips_isa_pkg::cls_addiu,
                                         mips_isa_pkg::cls_slti};

    always_comb begin
        alu_op        = cu_ctrl_pkg::alu_pass_a;
        alu_src_a     = 1'b0;
        alu_src_b     = cu_ctrl_pkg::srcb_b;
        pc_src        = cu_ctrl_pkg::pcsrc_alu;
        iord          = cu_ctrl_pkg::iord_pc;
        mem_to_reg    = cu_ctrl_pkg::m2r_aluout;
        reg_dst       = cu_ctrl_pkg::rdst_rt;
        branch_op     = cu_ctrl_pkg::br_eq;
        load_size     = cu_ctrl_pkg::lsize_word;
        pc_write      = 1'b0;
        pc_write_cond = 1'b0;
        reg_write     = 1'b0;
        mem_write     = 1'b0;   // No stores in this subset
        ir_load       = 1'b0;
        ab_load       = 1'b0;
        aluout_load   = 1'b0;
        epc_load      = 1'b0;
        hilo_load     = 1'b0;
        hilo_src      = 1'b0;
        mdr_load      = 1'b0;
        mult_start    = 1'b0;
        div_start     = 1'b0;

        case (state)
            cu_ctrl_pkg::st_fetch2: begin
                pc_write  = 1'b1;   // PC + 4
                alu_op    = cu_ctrl_pkg::alu_add;
                alu_src_b = cu_ctrl_pkg::srcb_four;
            end
            cu_ctrl_pkg::st_decode1: ir_load = 1'b1;
            cu_ctrl_pkg::st_decode2: ab_load = 1'b1;
            cu_ctrl_pkg::st_decode3: begin
                aluout_load = 1'b1; // Branch target ahead of time
                alu_op      = cu_ctrl_pkg::alu_add;
                alu_src_b   = cu_ctrl_pkg::srcb_offset;
            end
            cu_ctrl_pkg::st_exec: begin
                aluout_load = 1'b1;
                alu_src_a   = (instr_class != mips_isa_pkg::cls_jal); // JAL links the PC
                if (use_imm)
                    alu_src_b = cu_ctrl_pkg::srcb_imm;
                case (instr_class)
                    mips_isa_pkg::cls_add, mips_isa_pkg::cls_addi, mips_isa_pkg::cls_addiu:
                        alu_op = cu_ctrl_pkg::alu_add;
                    mips_isa_pkg::cls_sub: alu_op = cu_ctrl_pkg::alu_sub;
                    mips_isa_pkg::cls_and: alu_op = cu_ctrl_pkg::alu_and;
                    mips_isa_pkg::cls_slt, mips_isa_pkg::cls_slti:
                        alu_op = cu_ctrl_pkg::alu_cmp;
                    default: alu_op = cu_ctrl_pkg::alu_pass_a;
                endcase
            end
            cu_ctrl_pkg::st_writeback: begin
                reg_write = 1'b1;
                case (instr_class)
                    mips_isa_pkg::cls_add, mips_isa_pkg::cls_sub, mips_isa_pkg::cls_and:
                        reg_dst = cu_ctrl_pkg::rdst_rd;
                    mips_isa_pkg::cls_slt, mips_isa_pkg::cls_slti: begin
                        // Compare flag has to be live during the write
                        mem_to_reg = cu_ctrl_pkg::m2r_cmp;
                        alu_op     = cu_ctrl_pkg::alu_cmp;
                        alu_src_a  = 1'b1;
                        if (use_imm)
                            alu_src_b = cu_ctrl_pkg::srcb_imm;
                        else
                            reg_dst = cu_ctrl_pkg::rdst_rd;
                    end
                    mips_isa_pkg::cls_lui: mem_to_reg = cu_ctrl_pkg::m2r_lui;
                    mips_isa_pkg::cls_mfhi: begin
                        mem_to_reg = cu_ctrl_pkg::m2r_hi;
                        reg_dst    = cu_ctrl_pkg::rdst_rd;
                    end
                    mips_isa_pkg::cls_mflo: begin
                        mem_to_reg = cu_ctrl_pkg::m2r_lo;
                        reg_dst    = cu_ctrl_pkg::rdst_rd;
                    end
                    mips_isa_pkg::cls_jal: reg_dst = cu_ctrl_pkg::rdst_ra;
                    default: reg_dst = cu_ctrl_pkg::rdst_rt; // ADDI, ADDIU
                endcase
            end
            cu_ctrl_pkg::st_branch: begin
                pc_write_cond = 1'b1;
                alu_op        = cu_ctrl_pkg::alu_cmp;
                alu_src_a     = 1'b1;
                pc_src        = cu_ctrl_pkg::pcsrc_aluout;
                case (instr_class)
                    mips_isa_pkg::cls_bne: branch_op = cu_ctrl_pkg::br_ne;
                    mips_isa_pkg::cls_bgt: branch_op = cu_ctrl_pkg::br_gt;
                    mips_isa_pkg::cls_ble: branch_op = cu_ctrl_pkg::br_le;
                    default:               branch_op = cu_ctrl_pkg::br_eq;
                endcase
            end
            cu_ctrl_pkg::st_jump: begin
                pc_write = 1'b1;
                if (instr_class == mips_isa_pkg::cls_jr)
                    alu_src_a = 1'b1;   // rs through the ALU
                else
                    pc_src = cu_ctrl_pkg::pcsrc_jump;
            end
            cu_ctrl_pkg::st_muldiv_start: begin
                mult_start = (instr_class == mips_isa_pkg::cls_mult);
                div_start  = (instr_class == mips_isa_pkg::cls_div);
            end
            cu_ctrl_pkg::st_hilo_write: begin
                hilo_load = 1'b1;
                hilo_src  = (instr_class == mips_isa_pkg::cls_mult);
            end
            cu_ctrl_pkg::st_trap_epc: begin
                epc_load  = 1'b1;   // Faulting PC is PC - 4
                alu_op    = cu_ctrl_pkg::alu_sub;
                alu_src_b = cu_ctrl_pkg::srcb_four;
            end
            cu_ctrl_pkg::st_trap_addr: begin
                case (trap_cause)
                    cu_ctrl_pkg::trap_overflow: iord = cu_ctrl_pkg::iord_ovf_vec;
                    cu_ctrl_pkg::trap_div_zero: iord = cu_ctrl_pkg::iord_dz_vec;
                    default:                    iord = cu_ctrl_pkg::iord_inv_vec;
                endcase
            end
            cu_ctrl_pkg::st_trap_load: begin
                mdr_load  = 1'b1;
                load_size = cu_ctrl_pkg::lsize_byte;
            end
            cu_ctrl_pkg::st_trap_jump: begin
                pc_write = 1'b1;
                pc_src   = cu_ctrl_pkg::pcsrc_vector;
            end
            default: ; // fetch1, decode4, muldiv wait, trap wait
        endcase
    end

endmodule

//--- control_unit.sv
`timescale 1ns/1ns

module control_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  mips_isa_pkg::opcode_t    op,
    input  mips_isa_pkg::funct_t     funct,
    input  logic                     overflow,
    input  logic                     mult_done,
    input  logic                     div_done,
    input  logic                     div_zero,
    output cu_ctrl_pkg::alu_op_t     alu_op,
    output logic                     alu_src_a,
    output cu_ctrl_pkg::alu_src_b_t  alu_src_b,
    output cu_ctrl_pkg::pc_src_t     pc_src,
    output cu_ctrl_pkg::iord_t       iord,
    output cu_ctrl_pkg::mem_to_reg_t mem_to_reg,
    output cu_ctrl_pkg::reg_dst_t    reg_dst,
    output cu_ctrl_pkg::branch_op_t  branch_op,
    output cu_ctrl_pkg::load_size_t  load_size,
    output logic                     pc_write,
    output logic                     pc_write_cond,
    output logic                     reg_write,
    output logic                     mem_write,
    output logic                     ir_load,
    output logic                     ab_load,
    output logic                     aluout_load,
    output logic                     epc_load,
    output logic                     hilo_load,
    output logic                     hilo_src,
    output logic                     mdr_load,
    output logic                     mult_start,
    output logic                     div_start
);

    mips_isa_pkg::instr_class_t instr_class;
    cu_ctrl_pkg::cu_state_t     state;
    cu_ctrl_pkg::trap_cause_t   trap_cause;

    instr_decoder instr_decoder_inst (
        .op          (op),
        .funct       (funct),
        .instr_class (instr_class)
    );

    cycle_sequencer cycle_sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .overflow    (overflow),
        .mult_done   (mult_done),
        .div_done    (div_done),
        .div_zero    (div_zero),
        .state       (state),
        .trap_cause  (trap_cause)
    );

    // Port names match the top level one to one
    control_encoder control_encoder_inst (.*);

endmodule

//--- control_unit_sva.sv
`timescale 1ns/1ns

module control_unit_sva (
    input logic clk,
    input logic reset,
    input logic pc_write,
    input logic pc_write_cond,
    input logic reg_write,
    input logic mem_write,
    input logic ir_load,
    input logic ab_load,
    input logic aluout_load,
    input logic epc_load,
    input logic hilo_load,
    input logic mdr_load,
    input logic mult_start,
    input logic div_start
);

    logic [11:0] strobes;

    assign strobes = {pc_write, pc_write_cond, reg_write, mem_write, ir_load, ab_load,
                      aluout_load, epc_load, hilo_load, mdr_load, mult_start, div_start};

    pc_write_excl: assert property (@(posedge clk) !(pc_write && pc_write_cond))
        else $error("pc_write and pc_write_cond high in the same cycle");

    mult_pulse: assert property (@(posedge clk) disable iff (reset) mult_start |=> !mult_start)
        else $error("mult_start high for more than one cycle");

    div_pulse: assert property (@(posedge clk) disable iff (reset) div_start |=> !div_start)
        else $error("div_start high for more than one cycle");

    // EPC save and register write come from different states
    write_excl: assert property (@(posedge clk) !(reg_write && epc_load))
        else $error("reg_write and epc_load high in the same cycle");

    reset_quiet: assert property (@(posedge clk) reset |-> strobes == 12'h000)
        else $error("Strobe active while reset is high");

endmodule

//--- control_unit_tb.sv
`timescale 1ns/1ns
`include "cu_params.svh"

module control_unit_tb;

    localparam int clk_period = 100;
    localparam int max_wait   = 8;   // Longest random mult/div latency
    localparam int n_runs     = 27;  // Instruction runs over all tests
    localparam logic [11:0] sb_pcw = 12'h800;
    localparam logic [11:0] sb_pcc = 12'h400;
    localparam logic [11:0] sb_rw  = 12'h200;
    localparam logic [11:0] sb_ir  = 12'h080;
    localparam logic [11:0] sb_ab  = 12'h040;
    localparam logic [11:0] sb_ao  = 12'h020;
    localparam logic [11:0] sb_epc = 12'h010;
    localparam logic [11:0] sb_hl  = 12'h008;
    localparam logic [11:0] sb_mdr = 12'h004;
    localparam logic [11:0] sb_ms  = 12'h002;
    localparam logic [11:0] sb_ds  = 12'h001;

    logic clk, reset, overflow, mult_done, div_done, div_zero;
    logic [`CU_OP_W-1:0]       op;
    logic [`CU_FUNCT_W-1:0]    funct;
    logic [`CU_ALUOP_W-1:0]    alu_op;
    logic                      alu_src_a;
    logic [`CU_SRCB_W-1:0]     alu_src_b;
    logic [`CU_PCSRC_W-1:0]    pc_src;
    logic [`CU_IORD_W-1:0]     iord;
    logic [`CU_MEMTOREG_W-1:0] mem_to_reg;
    logic [`CU_REGDST_W-1:0]   reg_dst;
    logic [`CU_BRANCHOP_W-1:0] branch_op;
    logic [`CU_LSIZE_W-1:0]    load_size;
    logic pc_write, pc_write_cond, reg_write, mem_write, ir_load, ab_load, aluout_load;
    logic epc_load, hilo_load, hilo_src, mdr_load, mult_start, div_start;
    logic [11:0] strobes;
    logic [11:0] exp_q[$];           // Expected strobes per cycle from fetch1
    int alu_log[64], srcb_log[64], pcsrc_log[64], iord_log[64];
    int m2r_log[64], dst_log[64], brop_log[64], lsize_log[64], hsrc_log[64], srca_log[64];
    int errors, tests_run, tests_failed;
    string cur_run;

    control_unit control_unit_inst (.*);
    bind control_unit control_unit_sva control_unit_sva_inst (.*);

    assign strobes = {pc_write, pc_write_cond, reg_write, mem_write, ir_load, ab_load,
                      aluout_load, epc_load, hilo_load, mdr_load, mult_start, div_start};

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((n_runs * 40 + max_wait) * clk_period);
        $display("Watchdog expired before all instruction runs finished");
        $display("Result: FAILED");
        $finish;
    end

    task automatic check_val(input string what, input int cyc, input int exp_v, input int act_v);
        assert (exp_v == act_v) else begin
            $display("Fail %s: %s in cycle %0d expected %0d actual %0d",
                     cur_run, what, cyc, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int e0);
        tests_run++;
        if (errors != e0)
            tests_failed++;
        $display("%-14s %0d failed checks", name, errors - e0);
    endtask

    // fetch1, fetch2, decode1 to decode4
    task automatic expect_prefix();
        exp_q = {12'h000, sb_pcw, sb_ir, sb_ab, sb_ao, 12'h000};
    endtask

    task automatic expect_trap();
        exp_q = {exp_q, sb_epc, 12'h000, 12'h000, sb_mdr, sb_pcw};
    endtask

    // Starts at fetch1 plus 10 ns and ends at the next fetch1 plus 10 ns
    task automatic run_instr(input string name, input logic [5:0] op_v, input logic [5:0] funct_v,
                             input logic ovf, input logic dz, input int done_at);
        cur_run = name;
        op = op_v;
        funct = funct_v;
        overflow = ovf;
        div_zero = dz;
        for (int c = 0; c < exp_q.size(); c++) begin
            if (c == done_at) begin
                mult_done = (funct_v != 6'h1a);
                div_done  = (funct_v == 6'h1a);
            end
            @(negedge clk);
            alu_log[c]   = alu_op;
            srca_log[c]  = alu_src_a;
            srcb_log[c]  = alu_src_b;
            pcsrc_log[c] = pc_src;
            iord_log[c]  = iord;
            m2r_log[c]   = mem_to_reg;
            dst_log[c]   = reg_dst;
            brop_log[c]  = branch_op;
            lsize_log[c] = load_size;
            hsrc_log[c]  = hilo_src;
            assert (strobes == exp_q[c]) else begin
                $display("Fail %s: strobes in cycle %0d expected %03h actual %03h",
                         name, c, exp_q[c], strobes);
                errors++;
            end
            @(posedge clk);
            #10;
        end
        overflow = 1'b0;
        div_zero = 1'b0;
        mult_done = 1'b0;
        div_done = 1'b0;
    endtask

    task automatic check_trap(input int first, input int vec);
        check_val("alu_op", first, 2, alu_log[first]);
        check_val("iord", first + 1, vec, iord_log[first + 1]);
        check_val("load_size", first + 3, 3, lsize_log[first + 3]);
        check_val("pc_src", first + 4, 6, pcsrc_log[first + 4]);
    endtask

    // ALU selects checked in exec, dst and m2r in writeback
    task automatic alu_run(input string name, input logic [5:0] op_v, input logic [5:0] funct_v,
                           input logic ovf, input int alu, input int srcb, input int dst,
                           input int m2r, input bit has_exec);
        int wb;
        wb = has_exec ? 7 : 6;
        expect_prefix();
        if (has_exec)
            exp_q.push_back(sb_ao);
        exp_q.push_back(sb_rw);
        run_instr(name, op_v, funct_v, ovf, 1'b0, -1);
        if (has_exec) begin
            check_val("alu_op", 6, alu, alu_log[6]);
            check_val("alu_src_a", 6, 1, srca_log[6]);   // Register A operand
            check_val("alu_src_b", 6, srcb, srcb_log[6]);
        end
        check_val("reg_dst", wb, dst, dst_log[wb]);
        check_val("mem_to_reg", wb, m2r, m2r_log[wb]);
    endtask

    task automatic trap_ovf_run(input string name, input logic [5:0] op_v, input logic [5:0] fn);
        expect_prefix();
        exp_q.push_back(sb_ao);
        expect_trap();
        run_instr(name, op_v, fn, 1'b1, 1'b0, -1);
        check_trap(7, 3);
    endtask

    task automatic muldiv_run(input string name, input logic [5:0] funct_v, input logic [11:0] st);
        int w;
        w = $urandom_range(max_wait - 1, 0);
        expect_prefix();
        exp_q.push_back(st);
        repeat (w + 1) exp_q.push_back(12'h000);   // Wait state
        exp_q.push_back(sb_hl);
        run_instr(name, 6'h00, funct_v, 1'b0, 1'b0, 7 + w);
        check_val("hilo_src", 8 + w, funct_v == 6'h18, hsrc_log[8 + w]);
    endtask

    task automatic test_reset_fetch();
        int e0;
        e0 = errors;
        cur_run = "reset";
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #5;
            assert (strobes == 12'h000) else begin
                $display("Fail reset: strobes expected 000 actual %03h", strobes);
                errors++;
            end
        end
        #5;
        reset = 1'b0;
        alu_run("and_after_reset", 6'h00, 6'h24, 1'b0, 3, 0, 3, 0, 1'b1);
        end_test("reset_fetch", e0);
    endtask

    task automatic test_alu_classes();
        int e0;
        e0 = errors;
        alu_run("add", 6'h00, 6'h20, 1'b0, 1, 0, 3, 0, 1'b1);
        alu_run("sub", 6'h00, 6'h22, 1'b0, 2, 0, 3, 0, 1'b1);
        alu_run("and", 6'h00, 6'h24, 1'b0, 3, 0, 3, 0, 1'b1);
        alu_run("slt", 6'h00, 6'h2a, 1'b0, 7, 0, 3, 8, 1'b1);
        alu_run("addi", 6'h08, 6'h00, 1'b0, 1, 2, 0, 0, 1'b1);
        alu_run("addiu", 6'h09, 6'h00, 1'b0, 1, 2, 0, 0, 1'b1);
        alu_run("slti", 6'h0a, 6'h00, 1'b0, 7, 2, 0, 8, 1'b1);
        alu_run("lui", 6'h0f, 6'h00, 1'b0, 0, 0, 0, 6, 1'b0);
        alu_run("mfhi", 6'h00, 6'h10, 1'b0, 0, 0, 3, 2, 1'b0);
        alu_run("mflo", 6'h00, 6'h12, 1'b0, 0, 0, 3, 3, 1'b0);
        alu_run("addiu_ovf", 6'h09, 6'h00, 1'b1, 1, 2, 0, 0, 1'b1); // Unsigned, no trap
        end_test("alu_classes", e0);
    endtask

    task automatic test_overflow_trap();
        int e0;
        e0 = errors;
        trap_ovf_run("add_ovf", 6'h00, 6'h20);
        trap_ovf_run("sub_ovf", 6'h00, 6'h22);
        trap_ovf_run("addi_ovf", 6'h08, 6'h00);
        end_test("overflow_trap", e0);
    endtask

    task automatic test_control_flow();
        int e0;
        int br_exp[4];
        string br_name[4];
        e0 = errors;
        br_exp = '{0, 1, 3, 2};
        br_name = '{"beq", "bne", "ble", "bgt"};
        for (int i = 0; i < 4; i++) begin
            expect_prefix();
            exp_q.push_back(sb_pcc);
            run_instr(br_name[i], 6'h04 + i[5:0], 6'h00, 1'b0, 1'b0, -1);
            check_val("branch_op", 6, br_exp[i], brop_log[6]);
            check_val("pc_src", 6, 1, pcsrc_log[6]);
        end
        expect_prefix();
        exp_q.push_back(sb_pcw);
        run_instr("j", 6'h02, 6'h00, 1'b0, 1'b0, -1);
        check_val("pc_src", 6, 2, pcsrc_log[6]);
        expect_prefix();
        exp_q = {exp_q, sb_ao, sb_rw, sb_pcw};
        run_instr("jal", 6'h03, 6'h00, 1'b0, 1'b0, -1);
        check_val("alu_op", 6, 0, alu_log[6]);
        check_val("alu_src_a", 6, 0, srca_log[6]);   // Return address from PC
        check_val("reg_dst", 7, 2, dst_log[7]);
        check_val("pc_src", 8, 2, pcsrc_log[8]);
        expect_prefix();
        exp_q = {exp_q, sb_ao, sb_pcw};
        run_instr("jr", 6'h00, 6'h08, 1'b0, 1'b0, -1);
        check_val("alu_op", 6, 0, alu_log[6]);
        check_val("alu_src_a", 6, 1, srca_log[6]);
        check_val("alu_src_a", 7, 1, srca_log[7]);
        check_val("pc_src", 7, 0, pcsrc_log[7]);
        end_test("control_flow", e0);
    endtask

    task automatic test_mult_div();
        int e0;
        e0 = errors;
        muldiv_run("mult", 6'h18, sb_ms);
        muldiv_run("div", 6'h1a, sb_ds);
        expect_prefix();
        exp_q = {exp_q, sb_ds, 12'h000};
        expect_trap();
        run_instr("div_zero", 6'h00, 6'h1a, 1'b0, 1'b1, -1);
        check_trap(8, 4);
        end_test("mult_div", e0);
    endtask

    task automatic test_invalid();
        int e0;
        e0 = errors;
        expect_prefix();
        expect_trap();
        run_instr("lw", 6'h23, 6'h00, 1'b0, 1'b0, -1);
        check_trap(6, 2);
        expect_prefix();
        expect_trap();
        run_instr("funct_3f", 6'h00, 6'h3f, 1'b0, 1'b0, -1);
        check_trap(6, 2);
        end_test("invalid_opcode", e0);
    endtask

    initial begin
        reset = 1'b1;
        op = '0;
        funct = '0;
        overflow = 1'b0;
        mult_done = 1'b0;
        div_done = 1'b0;
        div_zero = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(68847));
        test_reset_fetch();
        test_alu_classes();
        test_overflow_trap();
        test_control_flow();
        test_mult_div();
        test_invalid();
        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- control_unit.f
+incdir+.
mips_isa_pkg.sv
cu_ctrl_pkg.sv
instr_decoder.sv
cycle_sequencer.sv
control_encoder.sv
control_unit.sv
control_unit_sva.sv
control_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module control_unit_tb \
    -f control_unit.f -o control_unit_sim
./obj_dir/control_unit_sim | tee sim.log
if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
